/* Makefile */
# Verilator lint and simulation of the 68000 SDRAM controller

VERILATOR  ?= verilator
FILELIST   := project.f
TOP        := tbTop
RTL_TOP    := m68kSdramController
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing -j 0 -Wno-fatal
OBJ_DIR    := obj_dir
PASS_TEXT  := *** TEST PASSED ***

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)

/* bench/sdramChecker.sv */
////////////////////////////////////////////////////////////////////////////
// samples the controller pins as they were just before each rising edge
// expected holds the access in flight and its writeData is the word for reads too
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module sdramChecker #(
	parameter int RefreshInterval = 374
) (
	input logic Clock,
	input logic Reset_L,
	input logic SDram_CKE_H,
	input logic SDram_CS_L,
	input logic SDram_RAS_L,
	input logic SDram_CAS_L,
	input logic SDram_WE_L,
	input sdramPkg::rowAddr SDram_Addr,
	input sdramPkg::bankAddr SDram_BA,
	input sdramPkg::sdramWord SDram_DQ,
	input logic Dtack_L,
	input logic ResetOut_L,
	input cpuBusPkg::cpuData DataOut,
	input logic UDS_L,
	input logic LDS_L,
	input cpuBusPkg::memRequest expected,
	output int checkCount,
	output int mismatchCount,
	output int failCount
);

	// single write burst, CL 2, sequential, burst length 1
	localparam sdramPkg::rowAddr ModeExpected = 13'h220;
	localparam int RefreshSlack = 50;			// clocks a refresh may slip behind an access

	sdramPkg::sdramCmd cmd;
	sdramPkg::rowAddr colExpected;				// column with a10 set for auto precharge
	logic running;								// ResetOut_L has gone high
	logic lastWasPrechargeAll;
	logic accessOpen;							// activate seen and dtack not yet released
	logic accessIsRead;
	logic dtackWasLow;
	logic strobeWasLow;							// strobes on the edge where dtack may rise
	int initPrecharges;
	int initRefreshes;
	int modeSets;
	int sinceRefresh;

	assign cmd = {SDram_CKE_H, SDram_CS_L, SDram_RAS_L, SDram_CAS_L, SDram_WE_L};
	assign colExpected = {2'b00, 1'b1, expected.col};

	initial begin
		checkCount = 0;
		mismatchCount = 0;
		failCount = 0;
	end

	task automatic compareValue(input string name, input logic [31:0] want,
			input logic [31:0] got);
		checkCount++;
		if (want !== got) begin
			mismatchCount++;
			$display("mismatch %s: expected %h, actual %h", name, want, got);
		end
	endtask

	task automatic reportFailure(input string what);
		failCount++;
		$display("error at %0t ns: %s", $time, what);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// pin watcher
	////////////////////////////////////////////////////////////////////////////

	always @(posedge Clock) begin
		if (!Reset_L) begin
			compareValue("reset cke", 0, SDram_CKE_H);		// chip held in power-up
			compareValue("reset cpu reset out", 0, ResetOut_L);
			compareValue("reset dtack", 1, Dtack_L);
			running = 1'b0;
			lastWasPrechargeAll = 1'b0;
			accessOpen = 1'b0;
			accessIsRead = 1'b0;
			dtackWasLow = 1'b0;
			strobeWasLow = 1'b0;
			initPrecharges = 0;
			initRefreshes = 0;
			modeSets = 0;
			sinceRefresh = 0;
		end else if (!running) begin
			// count what the chip gets before the cpu runs
			if (cmd == sdramPkg::CmdPrecharge && SDram_Addr[10])
				initPrecharges++;
			if (cmd == sdramPkg::CmdRefresh)
				initRefreshes++;
			if (cmd == sdramPkg::CmdModeSet) begin
				modeSets++;
				compareValue("mode word", ModeExpected, SDram_Addr);
				compareValue("mode set bank", 0, SDram_BA);
			end
			if (cmd == sdramPkg::CmdActivate || cmd == sdramPkg::CmdRead
					|| cmd == sdramPkg::CmdWrite)
				reportFailure("access command issued before start-up finished");
			if (ResetOut_L) begin
				compareValue("start-up precharge-all count", 1, initPrecharges);
				compareValue("start-up refresh count", 10, initRefreshes);
				compareValue("start-up mode set count", 1, modeSets);
				running = 1'b1;
			end
		end else begin
			case (cmd)
				sdramPkg::CmdActivate: begin
					compareValue("activate row", expected.row, SDram_Addr);
					compareValue("activate bank", expected.bank, SDram_BA);
					accessOpen = 1'b1;
				end
				sdramPkg::CmdRead: begin
					compareValue("read column", colExpected, SDram_Addr);
					compareValue("read bank", expected.bank, SDram_BA);
					accessIsRead = 1'b1;
				end
				sdramPkg::CmdWrite: begin
					compareValue("write column", colExpected, SDram_Addr);
					compareValue("write bank", expected.bank, SDram_BA);
					compareValue("write data on dq", expected.writeData, SDram_DQ);
					accessIsRead = 1'b0;
				end
				sdramPkg::CmdRefresh: begin
					checkCount++;
					if (!lastWasPrechargeAll)
						reportFailure("auto refresh without a precharge-all before it");
				end
				sdramPkg::CmdModeSet, sdramPkg::CmdPowerUp:
					reportFailure("start-up command seen after the cpu was released");
				default: ;
			endcase

			if (sinceRefresh > RefreshInterval + RefreshSlack) begin
				reportFailure($sformatf("no auto refresh for %0d clocks", sinceRefresh));
				sinceRefresh = 0;					// one report per late refresh
			end

			// dtack only inside an access and released after both strobes
			if (!Dtack_L && !accessOpen)
				reportFailure("Dtack_L low outside a selected bus cycle");
			if (Dtack_L && dtackWasLow) begin
				if (strobeWasLow)
					reportFailure("Dtack_L rose while a data strobe was still low");
				if (accessIsRead)
					compareValue("read data", expected.writeData, DataOut);	// last captured word
				accessOpen = 1'b0;
			end
			dtackWasLow = !Dtack_L;
			strobeWasLow = !UDS_L || !LDS_L;
		end

		if (Reset_L) begin
			if (cmd != sdramPkg::CmdNop)
				lastWasPrechargeAll = (cmd == sdramPkg::CmdPrecharge) && SDram_Addr[10];
			sinceRefresh = (cmd == sdramPkg::CmdRefresh) ? 0 : sinceRefresh + 1;
		end
	end

endmodule

/* bench/tbTop.sv */
////////////////////////////////////////////////////////////////////////////
// bus tasks drive on the falling edge; the chip model answers reads CL 2
// clocks after it samples the read command; one access in flight at a time
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module tbTop;

	localparam int PowerUpCycles = 7;
	localparam int RefreshInterval = 374;
	localparam int WordCount = 20;
	localparam int AccessTimeout = 200;		// clocks with room for a refresh going first
	localparam int StartTimeout = 1000;
	localparam int StrobeHold = 2;			// clocks the strobes stay low after dtack

	logic Clock;
	logic Reset_L;
	cpuBusPkg::cpuAddr Address;
	cpuBusPkg::cpuData DataIn;
	cpuBusPkg::cpuData DataOut;
	logic UDS_L;
	logic LDS_L;
	logic DramSelect_L;
	logic WE_L;
	logic AS_L;
	logic SDram_CKE_H;
	logic SDram_CS_L;
	logic SDram_RAS_L;
	logic SDram_CAS_L;
	logic SDram_WE_L;
	sdramPkg::rowAddr SDram_Addr;
	sdramPkg::bankAddr SDram_BA;
	wire sdramPkg::sdramWord SDram_DQ;
	logic Dtack_L;
	logic ResetOut_L;

	cpuBusPkg::memRequest expected;				// access the checker compares against
	cpuBusPkg::cpuData shadow [bit [24:0]];		// cpu word address -> last write
	cpuBusPkg::cpuAddr addrList [$];
	int timeoutCount;
	int checkCount;
	int mismatchCount;
	int failCount;

	// chip model state
	sdramPkg::sdramWord memory [bit [24:0]];	// {bank, row, col}
	sdramPkg::rowAddr openRow [4];
	logic [sdramPkg::CasLatency:0] readPipe;	// read command travelling to dq
	sdramPkg::sdramWord readWord;

	m68kSdramController #(
		.PowerUpCycles(PowerUpCycles),
		.RefreshInterval(RefreshInterval)
	) uut (
		.Clock(Clock), .Reset_L(Reset_L), .Address(Address), .DataIn(DataIn),
		.UDS_L(UDS_L), .LDS_L(LDS_L), .DramSelect_L(DramSelect_L), .WE_L(WE_L),
		.AS_L(AS_L), .DataOut(DataOut), .SDram_CKE_H(SDram_CKE_H),
		.SDram_CS_L(SDram_CS_L), .SDram_RAS_L(SDram_RAS_L), .SDram_CAS_L(SDram_CAS_L),
		.SDram_WE_L(SDram_WE_L), .SDram_Addr(SDram_Addr), .SDram_BA(SDram_BA),
		.SDram_DQ(SDram_DQ), .Dtack_L(Dtack_L), .ResetOut_L(ResetOut_L)
	);

	sdramChecker #(.RefreshInterval(RefreshInterval)) monitor (
		.Clock(Clock), .Reset_L(Reset_L), .SDram_CKE_H(SDram_CKE_H),
		.SDram_CS_L(SDram_CS_L), .SDram_RAS_L(SDram_RAS_L), .SDram_CAS_L(SDram_CAS_L),
		.SDram_WE_L(SDram_WE_L), .SDram_Addr(SDram_Addr), .SDram_BA(SDram_BA),
		.SDram_DQ(SDram_DQ), .Dtack_L(Dtack_L), .ResetOut_L(ResetOut_L),
		.DataOut(DataOut), .UDS_L(UDS_L), .LDS_L(LDS_L), .expected(expected),
		.checkCount(checkCount), .mismatchCount(mismatchCount), .failCount(failCount)
	);

	initial begin
		Clock = 1'b1;							// first event is a falling edge
		forever #5 Clock = ~Clock;
	end

	////////////////////////////////////////////////////////////////////////////
	// SDRAM chip model sampling the command pins on the rising edge
	////////////////////////////////////////////////////////////////////////////

	assign SDram_DQ = readPipe[sdramPkg::CasLatency] ? readWord : 'z;

	always @(posedge Clock) begin
		if (!Reset_L) begin
			readPipe <= '0;
		end else begin
			readPipe <= {readPipe[sdramPkg::CasLatency-1:0],
				{SDram_CKE_H, SDram_CS_L, SDram_RAS_L, SDram_CAS_L, SDram_WE_L}
				== sdramPkg::CmdRead};
			case ({SDram_CKE_H, SDram_CS_L, SDram_RAS_L, SDram_CAS_L, SDram_WE_L})
				sdramPkg::CmdActivate: openRow[SDram_BA] <= SDram_Addr;
				sdramPkg::CmdWrite:
					memory[{SDram_BA, openRow[SDram_BA], SDram_Addr[9:0]}] = SDram_DQ;
				sdramPkg::CmdRead:
					readWord <= memory[{SDram_BA, openRow[SDram_BA], SDram_Addr[9:0]}];
				default: ;
			endcase
		end
	end

	// bank 25..24, row 23..11, column 10..1; read data from the shadow copy
	function automatic cpuBusPkg::memRequest referenceAccess(input cpuBusPkg::cpuAddr addr,
			input logic isWrite, input cpuBusPkg::cpuData data);
		cpuBusPkg::memRequest r;
		r.bank = addr[25:24];
		r.row = addr[23:11];
		r.col = addr[10:1];
		r.isWrite = isWrite;
		r.writeData = isWrite ? data : shadow[addr[25:1]];
		return r;
	endfunction

	task automatic waitDtack(input logic level, input string what);
		int waited;
		waited = 0;
		while (Dtack_L !== level && waited < AccessTimeout) begin
			@(negedge Clock);
			waited++;
		end
		if (Dtack_L !== level) begin
			timeoutCount++;
			$display("timeout: Dtack_L did not go %0d within %0d clocks on %s",
				level, AccessTimeout, what);
		end
	endtask

	// one 68000 word cycle between two falling edges
	task automatic busCycle(input cpuBusPkg::cpuAddr addr, input logic isWrite,
			input cpuBusPkg::cpuData data);
		expected = referenceAccess(addr, isWrite, data);
		Address = addr;
		DataIn = ~data;							// bus not valid yet
		WE_L = !isWrite;
		AS_L = 1'b0;
		DramSelect_L = 1'b0;
		if (isWrite) begin
			repeat (2) @(negedge Clock);		// data and strobes follow AS on a write
			DataIn = data;
		end
		UDS_L = 1'b0;
		LDS_L = 1'b0;
		waitDtack(1'b0, isWrite ? "write" : "read");
		repeat (StrobeHold) @(negedge Clock);	// dtack has to wait for the strobes
		UDS_L = 1'b1;
		repeat (2) @(negedge Clock);			// lower byte strobe alone keeps the cycle open
		AS_L = 1'b1;
		DramSelect_L = 1'b1;
		LDS_L = 1'b1;
		WE_L = 1'b1;
		waitDtack(1'b1, "release");
		repeat (2) @(negedge Clock);			// idle gap between bus cycles
		if (isWrite)
			shadow[addr[25:1]] = data;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////////////////////

	initial begin
		cpuBusPkg::cpuAddr addr;
		int waited;
		void'($urandom(32'h56cb_f01e));
		Reset_L = 1'b1;
		Address = '0;
		DataIn = '0;
		UDS_L = 1'b1;
		LDS_L = 1'b1;
		DramSelect_L = 1'b1;
		WE_L = 1'b1;
		AS_L = 1'b1;
		expected = '0;
		timeoutCount = 0;
		@(negedge Clock);
		Reset_L = 1'b0;
		repeat (16) @(negedge Clock);
		Reset_L = 1'b1;

		waited = 0;								// start-up sequence
		while (!ResetOut_L && waited < StartTimeout) begin
			@(negedge Clock);
			waited++;
		end
		if (!ResetOut_L) begin
			timeoutCount++;
			$display("timeout: ResetOut_L still low %0d clocks after reset", StartTimeout);
		end

		for (int i = 0; i < WordCount; i++) begin
			addr = $urandom & 32'h03ff_fffe;	// bits 25..1 reach the chip
			addrList.push_back(addr);
			busCycle(addr, 1'b1, 16'($urandom));
		end
		foreach (addrList[i])
			busCycle(addrList[i], 1'b0, '0);

		repeat (3 * RefreshInterval) @(negedge Clock);	// only refreshes while idle
		repeat (2) @(negedge Clock);

		$display("checks %0d, mismatches %0d, other errors %0d, timeouts %0d",
			checkCount, mismatchCount, failCount, timeoutCount);
		if (mismatchCount == 0 && failCount == 0 && timeoutCount == 0 && checkCount > 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

/* hw/cpuBusDecode.sv */
////////////////////////////////////////////////////////////////////////////
// bus strobes are sampled once, so cycleActive lags the pins by a clock
// address bits 25..24 bank, 23..11 row, 10..1 column; the rest ignored
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module cpuBusDecode (
	input logic Clock,
	input logic Reset_L,
	input cpuBusPkg::cpuAddr Address,
	input cpuBusPkg::cpuData DataIn,
	input logic AS_L,
	input logic DramSelect_L,
	input logic WE_L,
	input logic UDS_L,
	input logic LDS_L,
	input logic ready,				// sequencer idle with no refresh due
	output logic reqValid,
	output cpuBusPkg::memRequest request,
	output logic strobeActive,
	output logic cycleActive
);

	logic armed;					// cleared once this bus cycle has been passed on

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			cycleActive <= 1'b0;
			strobeActive <= 1'b0;
			armed <= 1'b1;
		end else begin
			cycleActive <= !AS_L && !DramSelect_L;
			strobeActive <= !UDS_L || !LDS_L;		// either byte lane
			if (reqValid)
				armed <= 1'b0;
			else if (!cycleActive)
				armed <= 1'b1;					// bus cycle over, wait for the next
		end
	end

	// held off while the sequencer is busy, so nothing gets dropped
	assign reqValid = cycleActive && armed && ready;

	always_comb begin
		request.bank = Address[25:24];
		request.row = Address[23:11];
		request.col = Address[10:1];			// word address, a0 not on a 68000
		request.isWrite = !WE_L;
		request.writeData = DataIn;				// live bus, sequencer resamples on strobe
	end

endmodule

/* hw/cpuBusPkg.sv */
////////////////////////////////////////////////////////////////////////////
// 68000 side of the controller: 32-bit address, 16-bit data bus
// sequencer states are kept here with the request they act on
////////////////////////////////////////////////////////////////////////////

package cpuBusPkg;

	typedef logic [31:0] cpuAddr;
	typedef logic [15:0] cpuData;

	// one decoded cpu access
	typedef struct packed {
		sdramPkg::bankAddr bank;
		sdramPkg::rowAddr row;
		sdramPkg::colAddr col;
		logic isWrite;
		cpuData writeData;
	} memRequest;

	typedef enum logic [4:0] {
		SeqPowerUp, SeqFirstNop, SeqPrecharge, SeqInitRefresh,	// start-up
		SeqModeSet, SeqSettle,
		SeqIdle,
		SeqRefreshPrecharge, SeqRefresh,						// periodic refresh
		SeqActivate,
		SeqWriteWait, SeqWrite, SeqWriteNop,
		SeqRead, SeqReadWait,
		SeqTerminate											// hold dtack until strobes drop
	} seqState;

endpackage

/* hw/m68kSdramController.sv */
////////////////////////////////////////////////////////////////////////////
// 68000 bus to one SDRAM chip, decode -> sequencer -> pin registers
// PowerUpCycles sets the cke-low wait, RefreshInterval the refresh period
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module m68kSdramController #(
	parameter int PowerUpCycles = 7,
	parameter int RefreshInterval = 374
) (
	input logic Clock,
	input logic Reset_L,
	input cpuBusPkg::cpuAddr Address,
	input cpuBusPkg::cpuData DataIn,
	input logic UDS_L,
	input logic LDS_L,
	input logic DramSelect_L,
	input logic WE_L,
	input logic AS_L,
	output cpuBusPkg::cpuData DataOut,
	output logic SDram_CKE_H,
	output logic SDram_CS_L,
	output logic SDram_RAS_L,
	output logic SDram_CAS_L,
	output logic SDram_WE_L,
	output sdramPkg::rowAddr SDram_Addr,
	output sdramPkg::bankAddr SDram_BA,
	inout wire sdramPkg::sdramWord SDram_DQ,
	output logic Dtack_L,
	output logic ResetOut_L
);

	logic reqValid;
	logic ready;
	logic strobeActive;				// uds or lds low, one clock late
	logic cycleActive;				// as and dram select low, one clock late
	cpuBusPkg::memRequest request;
	sdramPkg::pinDrive drive;

	cpuBusDecode decode (
		.Clock(Clock),
		.Reset_L(Reset_L),
		.Address(Address),
		.DataIn(DataIn),
		.AS_L(AS_L),
		.DramSelect_L(DramSelect_L),
		.WE_L(WE_L),
		.UDS_L(UDS_L),
		.LDS_L(LDS_L),
		.ready(ready),
		.reqValid(reqValid),
		.request(request),
		.strobeActive(strobeActive),
		.cycleActive(cycleActive)
	);

	sdramSequencer #(
		.PowerUpCycles(PowerUpCycles),
		.RefreshInterval(RefreshInterval)
	) sequencer (
		.Clock(Clock),
		.Reset_L(Reset_L),
		.reqValid(reqValid),
		.request(request),
		.strobeActive(strobeActive),
		.cycleActive(cycleActive),
		.ready(ready),
		.drive(drive)
	);

	sdramIo io (
		.Clock(Clock),
		.Reset_L(Reset_L),
		.drive(drive),
		.SDram_CKE_H(SDram_CKE_H),
		.SDram_CS_L(SDram_CS_L),
		.SDram_RAS_L(SDram_RAS_L),
		.SDram_CAS_L(SDram_CAS_L),
		.SDram_WE_L(SDram_WE_L),
		.SDram_Addr(SDram_Addr),
		.SDram_BA(SDram_BA),
		.SDram_DQ(SDram_DQ),
		.Dtack_L(Dtack_L),
		.ResetOut_L(ResetOut_L),
		.DataOut(DataOut)
	);

endmodule

/* hw/sdramIo.sv */
////////////////////////////////////////////////////////////////////////////
// output register stage: every pin lags the sequencer by one clock
// read data is sampled on the falling edge, mid way through the dq window
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module sdramIo (
	input logic Clock,
	input logic Reset_L,
	input sdramPkg::pinDrive drive,
	output logic SDram_CKE_H,
	output logic SDram_CS_L,
	output logic SDram_RAS_L,
	output logic SDram_CAS_L,
	output logic SDram_WE_L,
	output sdramPkg::rowAddr SDram_Addr,
	output sdramPkg::bankAddr SDram_BA,
	inout wire sdramPkg::sdramWord SDram_DQ,
	output logic Dtack_L,
	output logic ResetOut_L,
	output cpuBusPkg::cpuData DataOut
);

	sdramPkg::sdramCmd cmdQ;
	sdramPkg::sdramWord dqOut;
	logic driveQ;					// dq output enable
	logic latchQ;

	////////////////////////////////////////////////////////////////////////////
	// control pins
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			cmdQ <= sdramPkg::CmdPowerUp;	// cke low during reset
			driveQ <= 1'b0;
			latchQ <= 1'b0;
			Dtack_L <= 1'b1;
			ResetOut_L <= 1'b0;				// cpu held until start-up is done
		end else begin
			cmdQ <= drive.cmd;
			driveQ <= drive.driveDq;
			latchQ <= drive.latchData;
			Dtack_L <= !drive.dtack;
			ResetOut_L <= drive.cpuRun;
		end
	end

	// address and data
	always_ff @(posedge Clock) begin
		SDram_Addr <= drive.addr;
		SDram_BA <= drive.bank;
		dqOut <= drive.writeData;
	end

	assign {SDram_CKE_H, SDram_CS_L, SDram_RAS_L, SDram_CAS_L, SDram_WE_L} = cmdQ;

	assign SDram_DQ = driveQ ? dqOut : 'z;	// chip drives the lines on reads

	// held for the cpu until the next read
	always_ff @(negedge Clock) begin
		if (latchQ)
			DataOut <= SDram_DQ;
	end

endmodule

/* hw/sdramPkg.sv */
////////////////////////////////////////////////////////////////////////////
// one 16-bit SDRAM chip: 13-bit rows, 10-bit columns, 4 banks, CL 2
// command codes and the pin struct from sequencer to io stage live here
////////////////////////////////////////////////////////////////////////////

package sdramPkg;

	// chip side vectors
	typedef logic [4:0] sdramCmd;		// {cke, cs_l, ras_l, cas_l, we_l}
	typedef logic [12:0] rowAddr;		// also the width of the address pins
	typedef logic [9:0] colAddr;
	typedef logic [1:0] bankAddr;
	typedef logic [15:0] sdramWord;

	////////////////////////////////////////////////////////////////////////////
	// commands, cke in the top bit
	////////////////////////////////////////////////////////////////////////////
	localparam sdramCmd CmdPowerUp   = 5'b00000;	// cke and cs low while power settles
	localparam sdramCmd CmdNop       = 5'b10111;
	localparam sdramCmd CmdActivate  = 5'b10011;	// row on addr, bank on ba
	localparam sdramCmd CmdRead      = 5'b10101;	// a10 high gives auto precharge
	localparam sdramCmd CmdWrite     = 5'b10100;	// a10 high gives auto precharge
	localparam sdramCmd CmdPrecharge = 5'b10010;	// a10 high means all banks
	localparam sdramCmd CmdRefresh   = 5'b10001;
	localparam sdramCmd CmdModeSet   = 5'b10000;	// ba = 0, mode word on addr

	// timing of the chip in clocks
	localparam int CasLatency = 2;
	localparam int InitRefreshes = 10;		// auto refreshes during start-up
	localparam int RefreshSpacing = 4;		// clocks reserved per auto refresh
	localparam int AutoPrechargeBit = 10;

	// single write burst, cas latency, sequential, burst length 1
	localparam rowAddr ModeWord = {3'b000, 1'b1, 2'b00, 3'(CasLatency), 1'b0, 3'b000};

	// one clock worth of pin values, registered by the io stage
	typedef struct packed {
		sdramCmd cmd;
		rowAddr addr;			// row, column or mode word
		bankAddr bank;
		logic driveDq;			// enable the dq drivers
		sdramWord writeData;
		logic latchData;		// sample dq on the following falling edge
		logic dtack;			// active high here, inverted at the pin
		logic cpuRun;			// releases the cpu reset
	} pinDrive;

endpackage

/* hw/sdramSequencer.sv */
////////////////////////////////////////////////////////////////////////////
// controller FSM: start-up sequence, periodic refresh, single word access
// a refresh that is due always goes ahead of a new cpu request
// reads and writes close their row with auto precharge
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module sdramSequencer #(
	parameter int PowerUpCycles = 7,		// clocks with cke low after reset
	parameter int RefreshInterval = 374		// clocks between periodic refreshes
) (
	input logic Clock,
	input logic Reset_L,
	input logic reqValid,
	input cpuBusPkg::memRequest request,
	input logic strobeActive,
	input logic cycleActive,
	output logic ready,
	output sdramPkg::pinDrive drive
);

	typedef logic [15:0] tickCount;

	localparam int SettleNops = 3;			// nops after the mode register load

	cpuBusPkg::seqState state, nextState;

	tickCount timer;						// general down counter, stops at 0
	tickCount timerValue;
	logic timerLoad;
	logic timerDone;

	tickCount refreshTimer;
	logic refreshLoad;
	logic refreshDue;
	logic refreshSlot;						// clock within a spacing slot to refresh

	cpuBusPkg::memRequest held;				// accepted request
	sdramPkg::rowAddr colWord;				// column with the auto precharge bit

	////////////////////////////////////////////////////////////////////////////
	// state and timers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			state <= cpuBusPkg::SeqPowerUp;
			timer <= tickCount'(PowerUpCycles);	// power-up wait starts with reset
			refreshTimer <= tickCount'(RefreshInterval);
		end else begin
			state <= nextState;
			if (timerLoad)
				timer <= timerValue;
			else if (!timerDone)
				timer <= timer - 1'b1;
			if (refreshLoad)
				refreshTimer <= tickCount'(RefreshInterval);
			else if (!refreshDue)
				refreshTimer <= refreshTimer - 1'b1;
		end
	end

	assign timerDone = (timer == '0);
	assign refreshDue = (refreshTimer == '0);
	assign refreshSlot = (timer % tickCount'(sdramPkg::RefreshSpacing))
		== tickCount'(sdramPkg::RefreshSpacing - 1);

	// no new cycle is taken while a refresh waits
	assign ready = (state == cpuBusPkg::SeqIdle) && !refreshDue;

	// address on accept, write data once the cpu has put it on the bus
	always_ff @(posedge Clock) begin
		if (ready && reqValid)
			held <= request;
		else if (state == cpuBusPkg::SeqWriteWait && strobeActive)
			held.writeData <= request.writeData;
	end

	always_comb begin
		colWord = '0;
		colWord[$bits(sdramPkg::colAddr)-1:0] = held.col;
		colWord[sdramPkg::AutoPrechargeBit] = 1'b1;
	end

	////////////////////////////////////////////////////////////////////////////
	// next state and pin values
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		nextState = state;
		timerLoad = 1'b0;
		timerValue = '0;
		refreshLoad = 1'b0;
		drive = '0;
		drive.cmd = sdramPkg::CmdNop;			// nop unless a state says otherwise
		drive.bank = held.bank;
		drive.writeData = held.writeData;
		drive.cpuRun = 1'b1;

		case (state)
			cpuBusPkg::SeqPowerUp: begin
				drive.cmd = sdramPkg::CmdPowerUp;
				drive.cpuRun = 1'b0;
				if (timerDone)
					nextState = cpuBusPkg::SeqFirstNop;
			end
			cpuBusPkg::SeqFirstNop: begin		// cke goes high here
				drive.cpuRun = 1'b0;
				nextState = cpuBusPkg::SeqPrecharge;
			end
			cpuBusPkg::SeqPrecharge: begin
				drive.cmd = sdramPkg::CmdPrecharge;
				drive.addr[sdramPkg::AutoPrechargeBit] = 1'b1;	// all banks
				drive.cpuRun = 1'b0;
				timerLoad = 1'b1;
				timerValue = tickCount'(sdramPkg::InitRefreshes * sdramPkg::RefreshSpacing);
				nextState = cpuBusPkg::SeqInitRefresh;
			end
			cpuBusPkg::SeqInitRefresh: begin
				drive.cpuRun = 1'b0;
				if (timerDone)
					nextState = cpuBusPkg::SeqModeSet;
				else if (refreshSlot)
					drive.cmd = sdramPkg::CmdRefresh;	// one per spacing slot
			end
			cpuBusPkg::SeqModeSet: begin
				drive.cmd = sdramPkg::CmdModeSet;
				drive.addr = sdramPkg::ModeWord;
				drive.bank = '0;
				drive.cpuRun = 1'b0;
				timerLoad = 1'b1;
				timerValue = tickCount'(SettleNops - 1);
				nextState = cpuBusPkg::SeqSettle;
			end
			cpuBusPkg::SeqSettle: begin
				drive.cpuRun = 1'b0;
				if (timerDone) begin
					refreshLoad = 1'b1;			// refresh interval starts now
					nextState = cpuBusPkg::SeqIdle;
				end
			end
			cpuBusPkg::SeqIdle: begin
				if (refreshDue)
					nextState = cpuBusPkg::SeqRefreshPrecharge;
				else if (reqValid)
					nextState = cpuBusPkg::SeqActivate;
			end
			cpuBusPkg::SeqRefreshPrecharge: begin
				drive.cmd = sdramPkg::CmdPrecharge;
				drive.addr[sdramPkg::AutoPrechargeBit] = 1'b1;
				timerLoad = 1'b1;
				timerValue = tickCount'(sdramPkg::RefreshSpacing);
				nextState = cpuBusPkg::SeqRefresh;
			end
			cpuBusPkg::SeqRefresh: begin
				if (timerDone) begin
					refreshLoad = 1'b1;
					nextState = cpuBusPkg::SeqIdle;
				end else if (refreshSlot) begin
					drive.cmd = sdramPkg::CmdRefresh;
				end
			end
			cpuBusPkg::SeqActivate: begin
				drive.cmd = sdramPkg::CmdActivate;
				drive.addr = held.row;
				nextState = held.isWrite ? cpuBusPkg::SeqWriteWait : cpuBusPkg::SeqRead;
			end
			cpuBusPkg::SeqWriteWait: begin		// data valid once uds or lds fall
				if (strobeActive)
					nextState = cpuBusPkg::SeqWrite;
			end
			cpuBusPkg::SeqWrite: begin
				drive.cmd = sdramPkg::CmdWrite;
				drive.addr = colWord;
				drive.driveDq = 1'b1;
				drive.dtack = 1'b1;
				nextState = cpuBusPkg::SeqWriteNop;
			end
			cpuBusPkg::SeqWriteNop: begin
				drive.driveDq = 1'b1;			// hold data one more clock
				drive.dtack = 1'b1;
				nextState = cpuBusPkg::SeqTerminate;
			end
			cpuBusPkg::SeqRead: begin
				drive.cmd = sdramPkg::CmdRead;
				drive.addr = colWord;
				timerLoad = 1'b1;
				timerValue = tickCount'(sdramPkg::CasLatency);
				nextState = cpuBusPkg::SeqReadWait;
			end
			cpuBusPkg::SeqReadWait: begin		// cas latency plus one clocks
				drive.latchData = 1'b1;
				drive.dtack = 1'b1;
				if (timerDone)
					nextState = cpuBusPkg::SeqTerminate;
			end
			cpuBusPkg::SeqTerminate: begin
				drive.dtack = strobeActive && cycleActive;
				if (!(strobeActive && cycleActive))
					nextState = cpuBusPkg::SeqIdle;
			end
			default: nextState = cpuBusPkg::SeqIdle;
		endcase
	end

endmodule

/* project.f */
hw/sdramPkg.sv
hw/cpuBusPkg.sv
hw/cpuBusDecode.sv
hw/sdramSequencer.sv
hw/sdramIo.sv
hw/m68kSdramController.sv
bench/sdramChecker.sv
bench/tbTop.sv
